// ==== include/mdec_params.svh ====
// MDEC colour conversion parameters
// Block geometry and fixed-point YUV to RGB coefficients (scaled by 1024)

`ifndef MDEC_PARAMS_SVH
`define MDEC_PARAMS_SVH

// --------------------
// Block geometry
// --------------------
`define MDEC_BLOCK_WORDS	64		// Samples in one 8x8 block
`define MDEC_ADR_W			6		// Chroma store address width

// --------------------
// Colour coefficients
// --------------------
// Fixed point, value x 1024
`define MDEC_COEF_CR_R		1436	// 1.402 on Cr for red
`define MDEC_COEF_CB_G		352		// 0.344 on Cb for green
`define MDEC_COEF_CR_G		731		// 0.714 on Cr for green
`define MDEC_COEF_CB_B		1815	// 1.772 on Cb for blue

// Arithmetic shift back to integer
`define MDEC_COEF_SHIFT		10

`endif

// ==== src/mdec_pkg.sv ====
// MDEC colour conversion types
// Sample kinds, receiver states and the sample, config and pixel records
// shared by the receiver, chroma store and conversion stage

`default_nettype none

package mdec_pkg;

	// Destination of an incoming sample
	typedef enum logic [1:0] {
		KIND_CR	= 2'd0,		// Red chroma, goes to Cr store
		KIND_CB	= 2'd1,		// Blue chroma, goes to Cb store
		KIND_Y	= 2'd2		// Luma, produces a pixel
	} sample_kind_e;

	// Four-phase receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE		= 2'd0,		// Waiting for request
		RX_ACK		= 2'd1,		// Ack raised, write strobe
		RX_RELEASE	= 2'd2		// Ack held until request drops
	} rx_state_e;

	// Conversion context carried with each sample
	typedef struct packed {
		logic	y_only;		// Monochrome, gray out + linear index
		logic	signed_out;	// Signed channels, else top bit flipped
	} conv_cfg_t;

	// One input sample, 20 bits
	typedef struct packed {
		sample_kind_e		kind;
		logic [1:0]			block_num;	// Bit 0 tile X, bit 1 tile Y
		logic [5:0]			idx;		// Position in 8x8 block
		logic signed [7:0]	value;
		conv_cfg_t			cfg;
	} sample_t;

	// One output pixel, 32 bits
	typedef struct packed {
		logic [7:0]	pix_idx;	// Position in 16x16 macroblock
		logic [7:0]	r;
		logic [7:0]	g;
		logic [7:0]	b;
	} pixel_t;

endpackage

`default_nettype wire

// ==== src/sample_receiver.sv ====
// Sample receiver
// Four-phase req/ack slave. Captures the sample on request and issues one
// write strobe per handshake, then holds ack until the source lets go

`timescale 1ns/1ps
`default_nettype none

module sample_receiver (
	input  wire logic				i_clk,
	input  wire logic				i_reset,

	// Source side
	input  wire logic				i_req,
	input  mdec_pkg::sample_t		i_sample,
	output logic					o_ack,

	// Write side
	output logic					o_wr_en,
	output mdec_pkg::sample_t		o_wr_sample
);

	mdec_pkg::rx_state_e	state;
	mdec_pkg::rx_state_e	state_nxt;
	mdec_pkg::sample_t		sample_q;	// Held for the whole handshake

	// --------------------
	// Next state
	// --------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			mdec_pkg::RX_IDLE:
			begin
				if (i_req)
					state_nxt = mdec_pkg::RX_ACK;	// Take it
			end
			mdec_pkg::RX_ACK:
				state_nxt = mdec_pkg::RX_RELEASE;	// Strobe is one cycle only
			mdec_pkg::RX_RELEASE:
			begin
				if (!i_req)
					state_nxt = mdec_pkg::RX_IDLE;	// Source done, drop ack
			end
			default:
				state_nxt = mdec_pkg::RX_IDLE;		// Unused encoding
		endcase
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			state <= mdec_pkg::RX_IDLE;
		else
			state <= state_nxt;
	end

	// Sample is stable while req high, grab it on the accepting edge
	always_ff @(posedge i_clk)
	begin
		if (state == mdec_pkg::RX_IDLE && i_req)
			sample_q <= i_sample;
	end

	// --------------------
	// Outputs
	// --------------------
	assign o_ack		= (state != mdec_pkg::RX_IDLE);	// High in ACK and RELEASE
	assign o_wr_en		= (state == mdec_pkg::RX_ACK);	// Single cycle per handshake
	assign o_wr_sample	= sample_q;

	// No new request until ack has dropped
	a_req_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
		$rose(i_req) |-> !o_ack)
		else $error("i_req rose again while o_ack was still high");

endmodule

`default_nettype wire

// ==== src/chroma_store.sv ====
// Chroma store
// Two 64 x 8 memories for Cr and Cb, one shared write port selected by
// sample kind, both read at the same address with one cycle latency

`timescale 1ns/1ps
`default_nettype none

`include "mdec_params.svh"

module chroma_store (
	input  wire logic						i_clk,

	// Write from receiver
	input  wire logic						i_wr_en,
	input  mdec_pkg::sample_t				i_wr_sample,

	// Read from conversion stage
	input  wire logic [`MDEC_ADR_W-1:0]		i_rd_adr,
	output logic signed [7:0]				o_cr,
	output logic signed [7:0]				o_cb
);

	logic signed [7:0]	cr_mem [0:`MDEC_BLOCK_WORDS-1];
	logic signed [7:0]	cb_mem [0:`MDEC_BLOCK_WORDS-1];

	logic	wr_cr;
	logic	wr_cb;

	// Y samples never touch the store
	assign wr_cr = i_wr_en && (i_wr_sample.kind == mdec_pkg::KIND_CR);
	assign wr_cb = i_wr_en && (i_wr_sample.kind == mdec_pkg::KIND_CB);

	// --------------------
	// Write port
	// --------------------
	always_ff @(posedge i_clk)
	begin
		if (wr_cr)
			cr_mem[i_wr_sample.idx] <= i_wr_sample.value;	// Linear idx in Cr block
		if (wr_cb)
			cb_mem[i_wr_sample.idx] <= i_wr_sample.value;	// Linear idx in Cb block
	end

	// --------------------
	// Read port
	// --------------------
	// Registered read, data valid the cycle after the address
	always_ff @(posedge i_clk)
	begin
		o_cr <= cr_mem[i_rd_adr];
		o_cb <= cb_mem[i_rd_adr];
	end

endmodule

`default_nettype wire

// ==== src/yuv_to_rgb_compute.sv ====
// YUV to RGB arithmetic
// Purely combinational fixed-point conversion of one Y with its Cr/Cb,
// saturated to 8 bits, with monochrome and unsigned output options

`timescale 1ns/1ps
`default_nettype none

`include "mdec_params.svh"

module yuv_to_rgb_compute (
	input  mdec_pkg::conv_cfg_t		i_cfg,
	input  wire logic signed [7:0]	i_y,
	input  wire logic signed [7:0]	i_cr,
	input  wire logic signed [7:0]	i_cb,
	output logic [7:0]				o_r,
	output logic [7:0]				o_g,
	output logic [7:0]				o_b
);

	// 13 bit signed holds coefficients up to 4095
	localparam logic signed [12:0] COEF_CR_R = 13'(`MDEC_COEF_CR_R);
	localparam logic signed [12:0] COEF_CB_G = 13'(`MDEC_COEF_CB_G);
	localparam logic signed [12:0] COEF_CR_G = 13'(`MDEC_COEF_CR_G);
	localparam logic signed [12:0] COEF_CB_B = 13'(`MDEC_COEF_CB_B);

	// Saturate to -128..127
	function automatic logic signed [7:0] clamp8(input logic signed [19:0] v);
		if (v > 20'sd127)
			return 8'sd127;
		else if (v < -20'sd128)
			return -8'sd128;
		else
			return v[7:0];
	endfunction

	// Signed channel, or offset binary by flipping the sign bit
	function automatic logic [7:0] encode(input logic signed [7:0] v, input logic sgn);
		return sgn ? v : {~v[7], v[6:0]};
	endfunction

	// --------------------
	// Products, x1024
	// --------------------
	logic signed [19:0]	prod_r;		// Max 1436*128, fits easily
	logic signed [19:0]	prod_g;		// Sum of both green terms
	logic signed [19:0]	prod_b;

	assign prod_r = i_cr * COEF_CR_R;
	assign prod_g = (i_cb * COEF_CB_G) + (i_cr * COEF_CR_G);
	assign prod_b = i_cb * COEF_CB_B;

	// --------------------
	// Add luma, clamp
	// --------------------
	logic signed [19:0]	sum_r;
	logic signed [19:0]	sum_g;
	logic signed [19:0]	sum_b;
	logic signed [7:0]	sat_r;
	logic signed [7:0]	sat_g;
	logic signed [7:0]	sat_b;

	assign sum_r = i_y + (prod_r >>> `MDEC_COEF_SHIFT);	// Arithmetic shift keeps sign
	assign sum_g = i_y - (prod_g >>> `MDEC_COEF_SHIFT);
	assign sum_b = i_y + (prod_b >>> `MDEC_COEF_SHIFT);

	assign sat_r = i_cfg.y_only ? i_y : clamp8(sum_r);		// Gray ignores chroma
	assign sat_g = i_cfg.y_only ? i_y : clamp8(sum_g);
	assign sat_b = i_cfg.y_only ? i_y : clamp8(sum_b);

	// Output encoding
	assign o_r = encode(sat_r, i_cfg.signed_out);
	assign o_g = encode(sat_g, i_cfg.signed_out);
	assign o_b = encode(sat_b, i_cfg.signed_out);

endmodule

`default_nettype wire

// ==== src/yuv_to_rgb_stage.sv ====
// YUV to RGB pipeline stage
// Builds the chroma read address and pixel index from a Y sample, holds
// the sample one cycle while the chroma read returns, then converts

`timescale 1ns/1ps
`default_nettype none

`include "mdec_params.svh"

module yuv_to_rgb_stage (
	input  wire logic						i_clk,
	input  wire logic						i_reset,

	// Sample from receiver
	input  wire logic						i_wr_en,
	input  mdec_pkg::sample_t				i_wr_sample,

	// Chroma store read
	output logic [`MDEC_ADR_W-1:0]			o_rd_adr,
	input  wire logic signed [7:0]			i_cr,
	input  wire logic signed [7:0]			i_cb,

	// Pixel out, no back-pressure
	output logic							o_pix_wr,
	output mdec_pkg::pixel_t				o_pixel
);

	// --------------------
	// Cycle n, addressing
	// --------------------
	logic		tile_x;
	logic		tile_y;
	logic		y_wr;
	logic [7:0]	pix_idx;

	assign tile_x	= i_wr_sample.block_num[0];
	assign tile_y	= i_wr_sample.block_num[1];
	assign y_wr		= i_wr_en && (i_wr_sample.kind == mdec_pkg::KIND_Y);

	// Chroma is 2x subsampled, one Cr/Cb entry per 2x2 luma pixels
	assign o_rd_adr	= {tile_y, i_wr_sample.idx[2:1], tile_x, i_wr_sample.idx[5:4]};

	// Macroblock position, or plain idx in mono
	assign pix_idx	= i_wr_sample.cfg.y_only
					? {2'b00, i_wr_sample.idx}
					: {tile_y, i_wr_sample.idx[2:0], tile_x, i_wr_sample.idx[5:3]};

	// --------------------
	// Cycle n+1, convert
	// --------------------
	logic					p_valid;
	logic signed [7:0]		p_y;
	logic [7:0]				p_idx;
	mdec_pkg::conv_cfg_t	p_cfg;		// Context travels with the sample
	logic [7:0]				conv_r;
	logic [7:0]				conv_g;
	logic [7:0]				conv_b;

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			p_valid <= 1'b0;
		else
			p_valid <= y_wr;	// Chroma writes make no pixel
	end

	always_ff @(posedge i_clk)
	begin
		if (y_wr)
		begin
			p_y		<= i_wr_sample.value;
			p_idx	<= pix_idx;
			p_cfg	<= i_wr_sample.cfg;
		end
	end

	yuv_to_rgb_compute u_compute (
		.i_cfg	(p_cfg),
		.i_y	(p_y),
		.i_cr	(i_cr),		// Store output lines up with p_y
		.i_cb	(i_cb),
		.o_r	(conv_r),
		.o_g	(conv_g),
		.o_b	(conv_b)
	);

	assign o_pix_wr	= p_valid;
	assign o_pixel	= mdec_pkg::pixel_t'{pix_idx: p_idx, r: conv_r, g: conv_g, b: conv_b};

	// Stage holds at most one pixel at a time
	a_one_in_flight: assert property (@(posedge i_clk) disable iff (i_reset)
		y_wr |-> !p_valid)
		else $error("Y sample arrived while a pixel was still in flight");

endmodule

`default_nettype wire

// ==== src/color_convert_top.sv ====
// Colour conversion top
// Four-phase sample input, Cr/Cb block storage and YUV to RGB stage
// producing one indexed pixel per Y sample

`timescale 1ns/1ps
`default_nettype none

`include "mdec_params.svh"

module color_convert_top (
	input  wire logic				i_clk,
	input  wire logic				i_reset,

	// Sample source, four-phase
	input  wire logic				i_req,
	input  mdec_pkg::sample_t		i_sample,
	output logic					o_ack,

	// Pixel sink
	output logic					o_pix_wr,
	output mdec_pkg::pixel_t		o_pixel
);

	// --------------------
	// Internal wiring
	// --------------------
	logic						wr_en;		// One cycle per accepted sample
	mdec_pkg::sample_t			wr_sample;
	logic [`MDEC_ADR_W-1:0]		rd_adr;
	logic signed [7:0]			rd_cr;
	logic signed [7:0]			rd_cb;

	sample_receiver u_receiver (
		.i_clk			(i_clk),
		.i_reset		(i_reset),
		.i_req			(i_req),
		.i_sample		(i_sample),
		.o_ack			(o_ack),
		.o_wr_en		(wr_en),
		.o_wr_sample	(wr_sample)
	);

	// Takes only Cr and Cb
	chroma_store u_chroma (
		.i_clk			(i_clk),
		.i_wr_en		(wr_en),
		.i_wr_sample	(wr_sample),
		.i_rd_adr		(rd_adr),
		.o_cr			(rd_cr),
		.o_cb			(rd_cb)
	);

	// Takes only Y
	yuv_to_rgb_stage u_stage (
		.i_clk			(i_clk),
		.i_reset		(i_reset),
		.i_wr_en		(wr_en),
		.i_wr_sample	(wr_sample),
		.o_rd_adr		(rd_adr),
		.i_cr			(rd_cr),
		.i_cb			(rd_cb),
		.o_pix_wr		(o_pix_wr),
		.o_pixel		(o_pixel)
	);

endmodule

`default_nettype wire

// ==== tests/tb_color_convert.sv ====
// Colour conversion testbench
// Four-phase driver applies a stimulus table, a reference model predicts
// each pixel and a monitor compares every o_pix_wr against it in order

`timescale 1ns/1ps
`default_nettype none

`include "mdec_params.svh"

module tb_color_convert;

	// One row of the stimulus table
	typedef struct {
		mdec_pkg::sample_kind_e	kind;
		logic [1:0]				block_num;
		logic [5:0]				idx;
		logic signed [7:0]		value;
		logic					y_only;
		logic					signed_out;
		int						rel_delay;	// Cycles req held after ack
	} stim_t;

	logic					i_clk;
	logic					i_reset;
	logic					i_req;
	mdec_pkg::sample_t		i_sample;
	logic					o_ack;
	logic					o_pix_wr;
	mdec_pkg::pixel_t		o_pixel;

	stim_t					table_q[$];
	mdec_pkg::pixel_t		exp_q[$];		// Predicted pixels, oldest first
	mdec_pkg::pixel_t		exp_pix;
	logic signed [7:0]		cr_ref [0:`MDEC_BLOCK_WORDS-1];	// Model copy of Cr block
	logic signed [7:0]		cb_ref [0:`MDEC_BLOCK_WORDS-1];
	logic [15:0]			lfsr_state;
	int						max_delay = 0;
	int						cycle_cnt = 0;
	int						cycle_limit = 100000;	// Replaced once table is built

	color_convert_top u_dut (
		.i_clk		(i_clk),
		.i_reset	(i_reset),
		.i_req		(i_req),
		.i_sample	(i_sample),
		.o_ack		(o_ack),
		.o_pix_wr	(o_pix_wr),
		.o_pixel	(o_pixel)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;	// 4 ns period
	end

	// --------------------
	// Helpers
	// --------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// 16-bit Fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};	// One step per bit
		end
		return v;
	endfunction

	// Saturate then optionally go to offset binary
	function automatic logic [7:0] to_channel(input int v, input logic signed_out);
		logic [7:0] c;
		if (v > 127)
			c = 8'h7f;
		else if (v < -128)
			c = 8'h80;
		else
			c = v[7:0];
		return signed_out ? c : (c ^ 8'h80);
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic mdec_pkg::pixel_t expected_pixel(input mdec_pkg::sample_t s);
		mdec_pkg::pixel_t p;
		int tx, ty, col, row, adr, y, cr, cb;
		tx	= s.block_num[0];
		ty	= s.block_num[1];
		col	= s.idx % 8;
		row	= s.idx / 8;
		y	= $signed(s.value);
		if (s.cfg.y_only)
		begin
			p.pix_idx = s.idx;	// Linear, top bits zero
			p.r = to_channel(y, s.cfg.signed_out);
			p.g = p.r;
			p.b = p.r;
		end
		else
		begin
			adr	= ty * 32 + (col / 2) * 8 + tx * 4 + row / 2;	// One chroma per 2x2 lumas
			cr	= cr_ref[adr];
			cb	= cb_ref[adr];
			p.pix_idx = ty * 128 + col * 16 + tx * 8 + row;
			p.r = to_channel(y + ((`MDEC_COEF_CR_R * cr) >>> `MDEC_COEF_SHIFT), s.cfg.signed_out);
			p.g = to_channel(y - ((`MDEC_COEF_CB_G * cb + `MDEC_COEF_CR_G * cr)
				>>> `MDEC_COEF_SHIFT), s.cfg.signed_out);
			p.b = to_channel(y + ((`MDEC_COEF_CB_B * cb) >>> `MDEC_COEF_SHIFT), s.cfg.signed_out);
		end
		return p;
	endfunction

	// --------------------
	// Stimulus table
	// --------------------
	function automatic void add_entry(input mdec_pkg::sample_kind_e kind, input logic [1:0] blk,
		input logic [5:0] idx, input logic [7:0] val, input logic yo, input logic so, input int dly);
		table_q.push_back('{kind, blk, idx, val, yo, so, dly});
		if (dly > max_delay)
			max_delay = dly;
	endfunction

	function automatic void build_table();
		int corners [6] = '{0, 7, 27, 36, 56, 63};	// Block corners and middle
		logic [7:0] v;
		for (int i = 0; i < `MDEC_BLOCK_WORDS; i++)
			add_entry(mdec_pkg::KIND_CR, 2'd0, i, take_bits(8), 1'b0, 1'b1, take_bits(2));
		for (int i = 0; i < `MDEC_BLOCK_WORDS; i++)
			add_entry(mdec_pkg::KIND_CB, 2'd0, i, take_bits(8), 1'b0, 1'b1, take_bits(2));
		// Every block, signed then unsigned for the same Y
		for (int blk = 0; blk < 4; blk++)
		begin
			for (int c = 0; c < 6; c++)
			begin
				v = take_bits(8);
				add_entry(mdec_pkg::KIND_Y, blk, corners[c], v, 1'b0, 1'b1, c % 3);
				add_entry(mdec_pkg::KIND_Y, blk, corners[c], v, 1'b0, 1'b0,
					(blk == 3 && c == 5) ? 12 : 1);	// One long release
			end
		end
		for (int c = 0; c < 6; c++)
			add_entry(mdec_pkg::KIND_Y, c % 4, corners[c], 8'h90 + c * 8, 1'b1, c % 2, 2);
		// Extremes at chroma entry 0, hit by block 0 idx 0
		add_entry(mdec_pkg::KIND_CR, 2'd0, 6'd0, 8'h7f, 1'b0, 1'b1, 0);
		add_entry(mdec_pkg::KIND_CB, 2'd0, 6'd0, 8'h7f, 1'b0, 1'b1, 0);
		add_entry(mdec_pkg::KIND_Y,  2'd0, 6'd0, 8'h7f, 1'b0, 1'b1, 0);
		add_entry(mdec_pkg::KIND_Y,  2'd0, 6'd0, 8'h80, 1'b0, 1'b1, 3);
		add_entry(mdec_pkg::KIND_CR, 2'd0, 6'd0, 8'h80, 1'b0, 1'b1, 0);
		add_entry(mdec_pkg::KIND_CB, 2'd0, 6'd0, 8'h80, 1'b0, 1'b1, 0);
		add_entry(mdec_pkg::KIND_Y,  2'd0, 6'd0, 8'h80, 1'b0, 1'b0, 0);
		add_entry(mdec_pkg::KIND_Y,  2'd0, 6'd0, 8'h7f, 1'b0, 1'b1, 5);
	endfunction

	// Four-phase driver, one sample per call
	task automatic apply_entry(input stim_t e);
		mdec_pkg::sample_t s;
		int n;
		s.kind			= e.kind;
		s.block_num		= e.block_num;
		s.idx			= e.idx;
		s.value			= e.value;
		s.cfg.y_only	= e.y_only;
		s.cfg.signed_out = e.signed_out;
		if (e.kind == mdec_pkg::KIND_Y)
			exp_q.push_back(expected_pixel(s));
		else if (e.kind == mdec_pkg::KIND_CR)
			cr_ref[e.idx] = e.value;
		else
			cb_ref[e.idx] = e.value;
		@(negedge i_clk);
		i_sample = s;
		i_req = 1'b1;
		n = 0;
		@(negedge i_clk);
		while (!o_ack)
		begin
			n++;
			if (n > 4)
				abort_run("No acknowledge within 4 cycles of a request");
			@(negedge i_clk);
		end
		// Ack must hold as long as req does
		repeat (e.rel_delay)
		begin
			@(negedge i_clk);
			check_value("o_ack", o_ack, 1'b1);
		end
		i_req = 1'b0;
		n = 0;
		@(negedge i_clk);
		while (o_ack)
		begin
			n++;
			if (n > 4)
				abort_run("Acknowledge stayed high after the request was released");
			@(negedge i_clk);
		end
	endtask

	// --------------------
	// Monitor and timeout
	// --------------------
	always @(negedge i_clk)
	begin
		if (!i_reset && o_pix_wr)
		begin
			if (exp_q.size() == 0)
				abort_run("Pixel strobe with no Y sample outstanding");
			else
			begin
				exp_pix = exp_q.pop_front();
				check_value("o_pixel.pix_idx", o_pixel.pix_idx, exp_pix.pix_idx);
				check_value("o_pixel.r", o_pixel.r, exp_pix.r);
				check_value("o_pixel.g", o_pixel.g, exp_pix.g);
				check_value("o_pixel.b", o_pixel.b, exp_pix.b);
			end
		end
	end

	always @(posedge i_clk)
	begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit)
			abort_run("Timeout, the run did not finish within its cycle limit");
	end

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		i_reset		= 1'b1;
		i_req		= 1'b0;
		i_sample	= '0;
		lfsr_state	= 16'd25210;
		build_table();
		cycle_limit = table_q.size() * (6 + max_delay) + 50;
		repeat (2) @(negedge i_clk);
		i_reset = 1'b0;
		@(negedge i_clk);
		check_value("o_ack", o_ack, 1'b0);			// Quiet after reset
		check_value("o_pix_wr", o_pix_wr, 1'b0);
		foreach (table_q[i])
			apply_entry(table_q[i]);
		repeat (4) @(negedge i_clk);				// Drain last pixel
		if (exp_q.size() != 0)
			abort_run("Fewer pixels came out than Y samples went in");
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
src/mdec_pkg.sv
src/sample_receiver.sv
src/chroma_store.sv
src/yuv_to_rgb_compute.sv
src/yuv_to_rgb_stage.sv
src/color_convert_top.sv
tests/tb_color_convert.sv
